//--- all.f
+incdir+test
rtl/imu_link_pkg.sv
rtl/imu_sample_latch.sv
rtl/spi_frame_tx.sv
rtl/imu_spi_top.sv
test/imu_spi_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the IMU SPI link testbench with Verilator and runs it.
# The run fails if the log holds the fail message.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir
BIN=imu_spi_sim

verilator --binary --timing -Wno-fatal \
    --top-module imu_spi_tb \
    -f all.f \
    --Mdir "$OBJ" -o "$BIN"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$OBJ/$BIN" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "FAIL: see errors above" "$LOG"; then
    echo "Simulation reported failure"
    exit 1
fi

if [ $sim_status -ne 0 ]; then
    echo "Simulator exited with status $sim_status"
    exit 1
fi

if ! grep -q "PASS: all tests" "$LOG"; then
    echo "Simulation ended without a result"
    exit 1
fi

echo "Simulation passed"
exit 0

//--- test/imu_frame_model.svh
`ifndef IMU_FRAME_MODEL_SVH
`define IMU_FRAME_MODEL_SVH

// ------------------------------------------------------------------------
// Reference model for one SPI frame
// ------------------------------------------------------------------------

// Builds the byte at wire position idx from the words the testbench drove
//   0      header
//   1-8    quat w, x, y, z, high byte first
//   9-14   gyro x, y, z, high byte first
//   15     flags, bit 0 quat new, bit 1 gyro new
function automatic logic [7:0] expected_byte(
    input int         idx,
    input logic [7:0] hdr,
    input imu_quat_t  q,
    input imu_vec3_t  g,
    input logic [1:0] flags
);
    logic [7:0] b;
    case (idx)
        0:       b = hdr;
        1:       b = q.w[15:8];
        2:       b = q.w[7:0];
        3:       b = q.x[15:8];
        4:       b = q.x[7:0];
        5:       b = q.y[15:8];
        6:       b = q.y[7:0];
        7:       b = q.z[15:8];
        8:       b = q.z[7:0];
        9:       b = g.x[15:8];        // Gyro block starts here
        10:      b = g.x[7:0];
        11:      b = g.y[15:8];
        12:      b = g.y[7:0];
        13:      b = g.z[15:8];
        14:      b = g.z[7:0];
        15:      b = {6'b000000, flags};
        default: b = 8'h00;            // Outside the frame
    endcase
    return b;
endfunction

`endif

//--- test/imu_spi_tb.sv
`timescale 1ns/100ps
`default_nettype none

module imu_spi_tb
    import imu_link_pkg::*;
();

    localparam logic [7:0] TB_HEADER    = 8'hAA;     // Default header of the DUT
    localparam int         SCK_HALF     = 8;         // sck half period in clocks
    localparam int         OE_TIMEOUT   = 20;        // Clocks allowed for sdo_oe to follow cs_n
    localparam int         RUN_LIMIT_NS = 2_000_000; // Whole-run watchdog

    logic      clk;
    logic      rst;
    logic      quat_valid;
    imu_quat_t quat;
    logic      gyro_valid;
    imu_vec3_t gyro;
    logic      cs_n;
    logic      sck;
    logic      sdi;
    logic      sdo;
    logic      sdo_oe;

    integer    seed;                        // $random state
    logic [7:0] rx_bytes [FRAME_BYTES];     // Bytes captured by the master
    imu_quat_t model_quat;                  // Words the latch should hold
    imu_vec3_t model_gyro;
    imu_quat_t next_quat;                   // Words strobed in the middle of a read
    imu_vec3_t next_gyro;

    `include "imu_frame_model.svh"

    imu_spi_top uut (
        .clk        (clk),
        .rst        (rst),
        .quat_valid (quat_valid),
        .quat       (quat),
        .gyro_valid (gyro_valid),
        .gyro       (gyro),
        .cs_n       (cs_n),
        .sck        (sck),
        .sdi        (sdi),
        .sdo        (sdo),
        .sdo_oe     (sdo_oe)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;              // 10 ns period
    end

    // ------------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------------

    task automatic stop_run(input string line);
        $display("%s", line);
        $display("FAIL: see errors above");
        $fatal(1, "Simulation stopped at first error");
    endtask

    task automatic wait_clocks(input int n);
        for (int i = 0; i < n; i++)
            @(negedge clk);                 // Stay on the drive edge
    endtask

    // sdo_oe follows the synchronized chip select a few clocks late
    task automatic wait_oe(input logic level);
        int cnt;
        cnt = 0;
        while (sdo_oe !== level && cnt < OE_TIMEOUT) begin
            @(negedge clk);
            cnt++;
        end
        if (sdo_oe !== level)
            stop_run($sformatf("Timeout at %0t: sdo_oe never went to %0b", $time, level));
    endtask

    function automatic imu_quat_t random_quat();
        imu_quat_t  q;
        logic [31:0] r;
        r   = $random(seed);
        q.w = r[15:0];
        q.x = r[31:16];
        r   = $random(seed);
        q.y = r[15:0];
        q.z = r[31:16];
        return q;
    endfunction

    function automatic imu_vec3_t random_gyro();
        imu_vec3_t  g;
        logic [31:0] r;
        r   = $random(seed);
        g.x = r[15:0];
        g.y = r[31:16];
        r   = $random(seed);
        g.z = r[15:0];
        return g;
    endfunction

    // One-cycle sensor strobes that may carry both words at once
    task automatic strobe_words(input logic do_q, input imu_quat_t q,
                                input logic do_g, input imu_vec3_t g);
        quat       = q;
        gyro       = g;
        quat_valid = do_q;
        gyro_valid = do_g;
        @(negedge clk);
        quat_valid = 1'b0;
        gyro_valid = 1'b0;
    endtask

    // ------------------------------------------------------------------------
    // SPI master, mode 0
    // ------------------------------------------------------------------------

    task automatic spi_bit(output logic b);
        sck = 1'b1;                         // Master samples on its rising edge
        b   = sdo;
        assert (sdo_oe === 1'b1) else begin
            stop_run($sformatf("Fail at %0t: sdo_oe low during a read", $time));
        end
        wait_clocks(SCK_HALF);
        sck = 1'b0;
        wait_clocks(SCK_HALF);
    endtask

    // update_at picks the byte before which next_quat and next_gyro are strobed
    task automatic read_frame(input int nbytes, input int update_at);
        logic [7:0] byte_v;
        logic       b;
        @(negedge clk);
        cs_n = 1'b0;
        wait_oe(1'b1);
        wait_clocks(SCK_HALF);              // sck idles low before the first rise
        for (int i = 0; i < nbytes; i++) begin
            if (i == update_at)
                strobe_words(1'b1, next_quat, 1'b1, next_gyro);
            byte_v = '0;
            for (int k = 0; k < 8; k++) begin
                spi_bit(b);
                byte_v = {byte_v[6:0], b};  // MSB first
            end
            rx_bytes[i] = byte_v;
        end
        cs_n = 1'b1;
        wait_oe(1'b0);
        wait_clocks(SCK_HALF);              // Idle gap before the next transfer
    endtask

    task automatic check_frame(input int nbytes, input logic [1:0] flags, input string tag);
        logic [7:0] exp_b;
        for (int i = 0; i < nbytes; i++) begin
            exp_b = expected_byte(i, TB_HEADER, model_quat, model_gyro, flags);
            assert (rx_bytes[i] === exp_b) else begin
                stop_run($sformatf("Fail at %0t: %s byte %0d got %02h expected %02h",
                                   $time, tag, i, rx_bytes[i], exp_b));
            end
        end
    endtask

    // ------------------------------------------------------------------------
    // Directed tests
    // ------------------------------------------------------------------------

    task automatic test_reset_frame();
        wait_clocks(4);
        assert (sdo_oe === 1'b0) else begin
            stop_run($sformatf("Fail at %0t: sdo_oe high with cs_n idle", $time));
        end
        read_frame(FRAME_BYTES, -1);
        check_frame(FRAME_BYTES, 2'b00, "reset frame");   // Header and zeros
    endtask

    task automatic test_fresh_data();
        model_quat = random_quat();
        model_gyro = random_gyro();
        strobe_words(1'b1, model_quat, 1'b1, model_gyro);
        read_frame(FRAME_BYTES, -1);
        check_frame(FRAME_BYTES, 2'b11, "fresh data");
    endtask

    task automatic test_flag_clearing();
        read_frame(FRAME_BYTES, -1);
        check_frame(FRAME_BYTES, 2'b00, "repeat read");  // Same words with the flags cleared
        model_gyro = random_gyro();
        strobe_words(1'b0, model_quat, 1'b1, model_gyro);
        read_frame(FRAME_BYTES, -1);
        check_frame(FRAME_BYTES, 2'b10, "gyro only");
    endtask

    task automatic test_partial_read();
        model_quat = random_quat();
        strobe_words(1'b1, model_quat, 1'b0, model_gyro);
        read_frame(5, -1);
        check_frame(5, 2'b01, "partial read");
        read_frame(FRAME_BYTES, -1);        // Starts over at the header
        check_frame(FRAME_BYTES, 2'b01, "after partial");
        read_frame(FRAME_BYTES, -1);
        check_frame(FRAME_BYTES, 2'b00, "after full");
    endtask

    task automatic test_update_during_read();
        next_quat = random_quat();
        next_gyro = random_gyro();
        read_frame(FRAME_BYTES, 8);         // Strobes land mid-frame
        check_frame(FRAME_BYTES, 2'b00, "frozen frame");
        model_quat = next_quat;
        model_gyro = next_gyro;
        // Flags set mid-frame were cleared when that frame completed
        read_frame(FRAME_BYTES, -1);
        check_frame(FRAME_BYTES, 2'b00, "updated words");
    endtask

    // ------------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------------

    initial begin
        seed        = 60265;
        rst         = 1'b1;
        quat_valid  = 1'b0;
        quat        = '0;
        gyro_valid  = 1'b0;
        gyro        = '0;
        cs_n        = 1'b1;                 // Bus idle
        sck         = 1'b0;                 // Mode 0 idle level
        sdi         = 1'b0;
        model_quat  = '0;
        model_gyro  = '0;
        next_quat   = '0;
        next_gyro   = '0;
        wait_clocks(3);                     // Reset over 3 rising edges
        rst = 1'b0;

        test_reset_frame();
        test_fresh_data();
        test_flag_clearing();
        test_partial_read();
        test_update_during_read();

        $display("PASS: all tests");
        $finish;
    end

    // Stops a run that outlives RUN_LIMIT_NS
    initial begin
        #(RUN_LIMIT_NS);
        $display("Timeout: simulation ran past its time limit");
        $display("FAIL: see errors above");
        $fatal(1, "Run time limit reached");
    end

endmodule

`default_nettype wire

//--- rtl/imu_spi_top.sv
`timescale 1ns/100ps
`default_nettype none

// Motion sensor to MCU link over SPI
// Sample latch feeds the frame transmitter, which reports full reads back
module imu_spi_top
    import imu_link_pkg::*;
#(
    parameter logic [7:0] HEADER_BYTE = 8'hAA,  // Frame header byte
    parameter int         SYNC_STAGES = 2       // SPI pin synchronizer depth
) (
    input  logic      clk,
    input  logic      rst,
    // Sensor side
    input  logic      quat_valid,
    input  imu_quat_t quat,
    input  logic      gyro_valid,
    input  imu_vec3_t gyro,
    // SPI pins
    input  logic      cs_n,
    input  logic      sck,
    input  logic      sdi,
    output logic      sdo,
    output logic      sdo_oe
);

    // ------------------------------------------------------------------------
    // Internal links
    // ------------------------------------------------------------------------

    imu_sample_t sample;                // Latch state toward the transmitter
    logic        frame_done;            // Full read, clears the new flags

    imu_sample_latch u_latch (
        .clk        (clk),
        .rst        (rst),
        .quat_valid (quat_valid),
        .quat       (quat),
        .gyro_valid (gyro_valid),
        .gyro       (gyro),
        .frame_done (frame_done),
        .sample     (sample)
    );

    spi_frame_tx #(
        .HEADER_BYTE (HEADER_BYTE),
        .SYNC_STAGES (SYNC_STAGES)
    ) u_tx (
        .clk        (clk),
        .rst        (rst),
        .cs_n       (cs_n),
        .sck        (sck),
        .sdi        (sdi),
        .sample     (sample),
        .sdo        (sdo),
        .sdo_oe     (sdo_oe),
        .frame_done (frame_done)
    );

endmodule

`default_nettype wire

//--- rtl/spi_frame_tx.sv
`timescale 1ns/100ps
`default_nettype none

// Read-only SPI mode 0 slave
// Frame is rebuilt from the latch while idle and frozen at chip select fall
// One bit moves out MSB first per synchronized sck rising edge
module spi_frame_tx
    import imu_link_pkg::*;
#(
    parameter logic [7:0] HEADER_BYTE = 8'hAA,  // First byte of every frame
    parameter int         SYNC_STAGES = 2       // Synchronizer depth of 2 or 3
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        cs_n,           // Raw active-low chip select
    input  logic        sck,            // Raw SPI clock
    input  logic        sdi,            // MOSI is accepted and ignored
    input  imu_sample_t sample,         // Live latch state
    output logic        sdo,            // MISO bit
    output logic        sdo_oe,         // Pad enable for MISO
    output logic        frame_done      // Pulse at the last bit of a full frame
);

    localparam int CNT_W = $clog2(FRAME_BITS);  // 7 bits for 128 positions

    // ------------------------------------------------------------------------
    // Pin synchronizers
    // ------------------------------------------------------------------------

    logic [SYNC_STAGES-1:0] cs_sync;    // cs_n chain with the oldest sample on top
    logic [SYNC_STAGES-1:0] sck_sync;   // sck chain
    logic                   sck_d;      // One flop past the chain for edge detection
    logic                   cs_s;       // Synchronized active-low chip select
    logic                   sck_s;
    logic                   sck_rise;

    // Chip select comes out of reset inactive, so sdo_oe starts low
    always_ff @(posedge clk) begin
        if (rst) begin
            cs_sync  <= '1;
            sck_sync <= '0;
            sck_d    <= 1'b0;
        end else begin
            cs_sync  <= {cs_sync[SYNC_STAGES-2:0], cs_n};
            sck_sync <= {sck_sync[SYNC_STAGES-2:0], sck};
            sck_d    <= sck_s;
        end
    end

    assign cs_s     = cs_sync[SYNC_STAGES-1];
    assign sck_s    = sck_sync[SYNC_STAGES-1];
    assign sck_rise = sck_s & ~sck_d;   // Master has just sampled the current bit

    // ------------------------------------------------------------------------
    // Frame packing
    // ------------------------------------------------------------------------

    logic [FRAME_BITS-1:0] frame_next;  // What a frame would hold right now

    // Header on top of the big-endian words and the flag byte at the bottom
    always_comb begin
        frame_next = {
            HEADER_BYTE,
            sample.quat.w,
            sample.quat.x,
            sample.quat.y,
            sample.quat.z,
            sample.gyro.x,
            sample.gyro.y,
            sample.gyro.z,
            6'b000000,
            sample.gyro_new,            // Flag bit 1
            sample.quat_new             // Flag bit 0
        };
    end

    // ------------------------------------------------------------------------
    // Shift register and bit counter
    // ------------------------------------------------------------------------

    logic [FRAME_BITS-1:0] frame_q;     // Frozen frame with the current bit on top
    logic [CNT_W-1:0]      bit_cnt;     // Bits already taken by the master
    logic                  last_bit;

    assign last_bit = (bit_cnt == CNT_W'(FRAME_BITS - 1));

    // Reloads from the latch while idle and rotates on each sck rise
    always_ff @(posedge clk) begin
        if (cs_s)
            frame_q <= frame_next;                          // Track latch while idle
        else if (sck_rise)
            frame_q <= {frame_q[FRAME_BITS-2:0], frame_q[FRAME_BITS-1]};
    end

    // Rotation above brings the header back after 128 bits in step with the wrap
    always_ff @(posedge clk) begin
        if (rst) begin
            bit_cnt    <= '0;
            frame_done <= 1'b0;
        end else begin
            frame_done <= 1'b0;
            if (cs_s) begin
                bit_cnt <= '0;                              // Restart at header MSB
            end else if (sck_rise) begin
                bit_cnt <= bit_cnt + 1'b1;                  // Wraps to 0 after bit 127
                if (last_bit)
                    frame_done <= 1'b1;                     // Whole frame delivered
            end
        end
    end

    // ------------------------------------------------------------------------
    // Outputs
    // ------------------------------------------------------------------------

    // Tri-state lives at the pad and only the enable level is made here
    assign sdo    = frame_q[FRAME_BITS-1];
    assign sdo_oe = ~cs_s;

    // sdi stays unconnected inside because the link is read only

endmodule

`default_nettype wire

//--- rtl/imu_sample_latch.sv
`timescale 1ns/100ps
`default_nettype none

// Holds the newest sensor words for the SPI side
// Each word has a sticky new flag, set by its strobe and cleared by a full read
module imu_sample_latch
    import imu_link_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        quat_valid,     // One-cycle strobe for quat
    input  imu_quat_t   quat,
    input  logic        gyro_valid,     // One-cycle strobe for gyro
    input  imu_vec3_t   gyro,
    input  logic        frame_done,     // Full 16-byte frame was shifted out
    output imu_sample_t sample
);

    // ------------------------------------------------------------------------
    // Word registers
    // ------------------------------------------------------------------------

    imu_quat_t quat_q;                  // Last quaternion seen
    imu_vec3_t gyro_q;                  // Last gyro vector seen

    // Words come up as zero so the first frame is well defined
    always_ff @(posedge clk) begin
        if (rst) begin
            quat_q <= '0;
            gyro_q <= '0;
        end else begin
            if (quat_valid)
                quat_q <= quat;         // Visible one edge after the strobe
            if (gyro_valid)
                gyro_q <= gyro;
        end
    end

    // ------------------------------------------------------------------------
    // Sticky new-data flags
    // ------------------------------------------------------------------------

    logic quat_new_q;
    logic gyro_new_q;

    // A strobe beats a coinciding frame_done, so fresh data is never lost
    always_ff @(posedge clk) begin
        if (rst) begin
            quat_new_q <= 1'b0;
            gyro_new_q <= 1'b0;
        end else begin
            if (quat_valid)
                quat_new_q <= 1'b1;
            else if (frame_done)
                quat_new_q <= 1'b0;     // MCU has read it

            if (gyro_valid)
                gyro_new_q <= 1'b1;
            else if (frame_done)
                gyro_new_q <= 1'b0;
        end
    end

    // ------------------------------------------------------------------------
    // Output bundle
    // ------------------------------------------------------------------------

    always_comb begin
        sample.quat     = quat_q;
        sample.gyro     = gyro_q;
        sample.quat_new = quat_new_q;
        sample.gyro_new = gyro_new_q;
    end

endmodule

`default_nettype wire

//--- rtl/imu_link_pkg.sv
`default_nettype none

package imu_link_pkg;

    // ------------------------------------------------------------------------
    // Sensor word types
    // ------------------------------------------------------------------------

    // One gyroscope reading, x in the top bits
    typedef struct packed {
        logic signed [15:0] x;
        logic signed [15:0] y;
        logic signed [15:0] z;
    } imu_vec3_t;                                   // 48 bits

    // One orientation quaternion, w in the top bits
    typedef struct packed {
        logic signed [15:0] w;
        logic signed [15:0] x;
        logic signed [15:0] y;
        logic signed [15:0] z;
    } imu_quat_t;                                   // 64 bits

    // Latch output as seen by the SPI side
    typedef struct packed {
        imu_quat_t quat;                            // Newest quaternion
        imu_vec3_t gyro;                            // Newest gyro vector
        logic      quat_new;                        // Quat arrived since last full read
        logic      gyro_new;                        // Gyro arrived since last full read
    } imu_sample_t;                                 // 114 bits

    // ------------------------------------------------------------------------
    // Frame geometry
    // ------------------------------------------------------------------------

    // Layout, MSB first on the wire
    //   byte 0      header
    //   bytes 1-8   quat w, x, y, z, high byte first
    //   bytes 9-14  gyro x, y, z, high byte first
    //   byte 15     flags, bit 0 quat new, bit 1 gyro new
    localparam int FRAME_BYTES = 16;                // Bytes per frame
    localparam int FRAME_BITS  = FRAME_BYTES * 8;   // Width of the frozen frame

endpackage

`default_nettype wire
